// ==== Makefile ====
TOP = pio_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// ==== common/pio_pkg.sv ====
`default_nettype none

package pio_pkg;

  typedef logic [15:0] instr_t;
  typedef logic [4:0]  addr_t;
  typedef logic [31:0] word_t;
  typedef logic [23:0] div_t;
  typedef logic [7:0]  pins_t;
  typedef logic [3:0]  count_t;

  // instruction bits 15..13
  typedef enum logic [2:0] {
    op_jmp  = 3'd0,
    op_wait = 3'd1,
    op_in   = 3'd2,
    op_out  = 3'd3,
    op_push = 3'd4,
    op_pull = 3'd5,
    op_set  = 3'd7
  } opcode_e;

  // jmp condition in bits 7..5
  typedef enum logic [2:0] {
    cond_always = 3'd0,
    cond_x_dec  = 3'd2,
    cond_pin    = 3'd6
  } jmp_cond_e;

  // set destination in bits 7..5
  typedef enum logic [2:0] {
    dest_pins    = 3'd0,
    dest_x       = 3'd1,
    dest_pindirs = 3'd4
  } set_dest_e;

  typedef enum logic [2:0] {
    act_none   = 3'd0,
    act_instr  = 3'd1,
    act_wrap   = 3'd2,
    act_pull   = 3'd3,
    act_push   = 3'd4,
    act_enable = 3'd5,
    act_div    = 3'd6
  } action_e;

  // 0 and anything above 8 mean 8 bits
  function automatic count_t bit_count(instr_t i);
    if (i[3:0] == 4'd0 || i[3:0] > 4'd8) begin
      return 4'd8;
    end
    return i[3:0];
  endfunction

  function automatic pins_t count_mask(count_t n);
    logic [8:0] m;
    m = (9'd1 << n) - 9'd1;
    return m[7:0];
  endfunction

endpackage

`default_nettype wire

// ==== filelist.f ====
common/pio_pkg.sv
hw/fifo.sv
machine/machine.sv
hw/pio.sv
testbench/pio_tb.sv

// ==== hw/fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module fifo #(
  parameter int depth = 4,
  parameter int width = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic             pull,
  input  logic [width-1:0] din,
  output logic [width-1:0] dout,
  output logic             empty,
  output logic             full
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [aw-1:0]    rd_ptr;
  logic [aw-1:0]    wr_ptr;
  logic [cw-1:0]    count;
  logic             do_push;
  logic             do_pull;

  assign empty   = (count == 0);
  assign full    = (count == cw'(depth));
  assign do_push = push && !full;
  assign do_pull = pull && !empty;
  // show-ahead head
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pull) begin
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pull) begin
        count <= count + 1'b1;
      end else if (do_pull && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= cw'(depth));

endmodule

`default_nettype wire

// ==== hw/pio.sv ====
`timescale 1ns/1ns
`default_nettype none

module pio import pio_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  div_t       div,
  input  logic [1:0] mindex,
  input  word_t      din,
  input  addr_t      index,
  input  action_e    action,
  input  word_t      gpio_in,
  output word_t      dout,
  output word_t      gpio_out,
  output word_t      gpio_dir,
  output logic [3:0] tx_full,
  output logic [3:0] rx_empty
);

  // shared program memory
  instr_t     mem [32];

  addr_t      pstart [4];
  addr_t      pend   [4];
  div_t       divs   [4];
  logic [3:0] en;

  addr_t      pc      [4];
  word_t      tx_dout [4];
  word_t      rx_din  [4];
  word_t      rx_dout [4];
  logic [3:0] tx_empty;
  logic [3:0] rx_full;
  logic [3:0] tx_pull;
  logic [3:0] rx_push;

  logic [3:0] sel;
  logic [3:0] host_push;
  logic [3:0] host_pull;

  assign sel       = 4'b0001 << mindex;
  assign host_push = (action == act_push) ? sel : 4'b0000;
  assign host_pull = (action == act_pull) ? sel : 4'b0000;
  assign dout      = rx_dout[mindex];

  always_ff @(posedge clk) begin
    if (action == act_instr) begin
      mem[index] <= din[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en <= 4'b0000;
      for (int i = 0; i < 4; i++) begin
        pstart[i] <= 5'd0;
        pend[i]   <= 5'd31;
        divs[i]   <= '0;
      end
    end else begin
      case (action)
        act_wrap: begin
          pstart[mindex] <= din[4:0];
          pend[mindex]   <= din[9:5];
        end
        act_enable: en <= din[3:0];
        act_div: divs[mindex] <= div;
        default: ;
      endcase
    end
  end

  for (genvar m = 0; m < 4; m++) begin : g_machine
    machine u_machine (
      .clk      (clk),
      .reset    (reset),
      .en       (en[m]),
      .div      (divs[m]),
      .instr    (mem[pc[m]]),
      .pstart   (pstart[m]),
      .pend     (pend[m]),
      .tx_data  (tx_dout[m]),
      .tx_empty (tx_empty[m]),
      .rx_full  (rx_full[m]),
      .pins_in  (gpio_in[8*m +: 8]),
      .pc       (pc[m]),
      .tx_pull  (tx_pull[m]),
      .rx_data  (rx_din[m]),
      .rx_push  (rx_push[m]),
      .pins_out (gpio_out[8*m +: 8]),
      .pins_dir (gpio_dir[8*m +: 8])
    );

    // host to machine
    fifo #(.depth(fifo_depth), .width($bits(word_t))) u_tx_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (host_push[m]),
      .pull  (tx_pull[m]),
      .din   (din),
      .dout  (tx_dout[m]),
      .empty (tx_empty[m]),
      .full  (tx_full[m])
    );

    // machine to host
    fifo #(.depth(fifo_depth), .width($bits(word_t))) u_rx_fifo (
      .clk   (clk),
      .reset (reset),
      .push  (rx_push[m]),
      .pull  (host_pull[m]),
      .din   (rx_din[m]),
      .dout  (rx_dout[m]),
      .empty (rx_empty[m]),
      .full  (rx_full[m])
    );
  end

endmodule

`default_nettype wire

// ==== machine/machine.sv ====
`timescale 1ns/1ns
`default_nettype none

module machine import pio_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   en,
  input  div_t   div,
  input  instr_t instr,
  input  addr_t  pstart,
  input  addr_t  pend,
  input  word_t  tx_data,
  input  logic   tx_empty,
  input  logic   rx_full,
  input  pins_t  pins_in,
  output addr_t  pc,
  output logic   tx_pull,
  output word_t  rx_data,
  output logic   rx_push,
  output pins_t  pins_out,
  output pins_t  pins_dir
);

  div_t      cnt;
  logic      en_q;
  logic      load;
  logic      step;
  logic      stall;
  logic      taken;
  addr_t     next_pc;
  word_t     isr;
  word_t     osr;
  word_t     x;

  opcode_e   op;
  jmp_cond_e cond;
  set_dest_e dest;
  count_t    count;
  pins_t     mask;

  assign op    = opcode_e'(instr[15:13]);
  assign cond  = jmp_cond_e'(instr[7:5]);
  assign dest  = set_dest_e'(instr[7:5]);
  assign count = bit_count(instr);
  assign mask  = count_mask(count);

  // rising enable reloads pc and stepping starts a clock later
  assign load = en && !en_q;
  assign step = en && en_q && (cnt >= div);

  always_comb begin
    stall = 1'b0;
    taken = 1'b0;
    case (op)
      op_wait: stall = (pins_in[instr[2:0]] != instr[7]);
      op_pull: stall = tx_empty;
      op_push: stall = rx_full;
      op_jmp: begin
        case (cond)
          cond_always: taken = 1'b1;
          cond_x_dec:  taken = (x != '0);
          cond_pin:    taken = pins_in[0];
          default:     taken = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  always_comb begin
    if (taken) begin
      next_pc = instr[4:0];
    end else if (pc == pend) begin
      next_pc = pstart;
    end else begin
      next_pc = pc + 5'd1;
    end
  end

  assign tx_pull = step && !stall && (op == op_pull);
  assign rx_push = step && !stall && (op == op_push);
  assign rx_data = isr;

  // divider counter
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt  <= '0;
      en_q <= 1'b0;
    end else begin
      en_q <= en;
      if (!en || !en_q || step) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 24'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= '0;
      isr      <= '0;
      osr      <= '0;
      x        <= '0;
      pins_out <= '0;
      pins_dir <= '0;
    end else if (load) begin
      pc <= pstart;
    end else if (step && !stall) begin
      pc <= next_pc;
      case (op)
        op_in: begin
          isr <= (isr << count) | word_t'(pins_in & mask);
        end
        op_out: begin
          // lsb first into the low pins
          pins_out <= (pins_out & ~mask) | (osr[7:0] & mask);
          osr      <= osr >> count;
        end
        op_push: isr <= '0;
        op_pull: osr <= tx_data;
        op_set: begin
          case (dest)
            dest_pins:    pins_out <= {3'b000, instr[4:0]};
            dest_pindirs: pins_dir <= {3'b000, instr[4:0]};
            dest_x:       x        <= {27'd0, instr[4:0]};
            default: ;
          endcase
        end
        op_jmp: begin
          // condition sees x before the decrement
          if (cond == cond_x_dec) begin
            x <= x - 32'd1;
          end
        end
        default: ;
      endcase
    end
  end

  a_no_pull_empty: assert property (@(posedge clk) disable iff (reset)
    tx_pull |-> !tx_empty);

  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    rx_push |-> !rx_full);

  a_pc_hold: assert property (@(posedge clk) disable iff (reset)
    (!step && !load) |=> $stable(pc));

endmodule

`default_nettype wire

// ==== testbench/pio_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pio_tb import pio_pkg::*; ();

  localparam int period          = 40;
  localparam int poll_limit      = 200;
  localparam int num_tests       = 6;
  localparam int max_test_cycles = 500;

  logic       clk;
  logic       reset;
  div_t       div;
  logic [1:0] mindex;
  word_t      din;
  addr_t      index;
  action_e    action;
  word_t      gpio_in;
  word_t      dout;
  word_t      gpio_out;
  word_t      gpio_dir;
  logic [3:0] tx_full;
  logic [3:0] rx_empty;

  pio #(.fifo_depth(4)) DUT (
    .clk      (clk),
    .reset    (reset),
    .div      (div),
    .mindex   (mindex),
    .din      (din),
    .index    (index),
    .action   (action),
    .gpio_in  (gpio_in),
    .dout     (dout),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir),
    .tx_full  (tx_full),
    .rx_empty (rx_empty)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic end_failed_run();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  // bound covers every test at its longest plus reset
  initial begin
    #((num_tests * max_test_cycles + 8) * period);
    $display("watchdog expired before the tests finished");
    end_failed_run();
  end

  task automatic check(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("Error: time %0t, %s: got %h, expected %h", $time, name, actual, expected);
      end_failed_run();
    end
  endtask

  function automatic instr_t set_instr(input set_dest_e d, input logic [4:0] v);
    return {op_set, 5'd0, d, v};
  endfunction

  function automatic instr_t jmp_instr(input jmp_cond_e c, input addr_t t);
    return {op_jmp, 5'd0, c, t};
  endfunction

  function automatic instr_t wait_instr(input logic pol, input logic [2:0] pin);
    return {op_wait, 5'd0, pol, 4'd0, pin};
  endfunction

  // in and out carry a bit count in 3..0
  function automatic instr_t shift_instr(input opcode_e op, input logic [3:0] n);
    return {op, 9'd0, n};
  endfunction

  function automatic instr_t plain_instr(input opcode_e op);
    return {op, 13'd0};
  endfunction

  function automatic pins_t window(input word_t w, input int m);
    return w[8*m +: 8];
  endfunction

  task automatic host_action(input action_e a, input logic [1:0] m, input word_t d,
                             input addr_t idx);
    @(posedge clk);
    #5;
    action = a;
    mindex = m;
    din    = d;
    index  = idx;
    @(posedge clk);
    #5;
    action = act_none;
  endtask

  task automatic load_program(input addr_t base, input instr_t prog[$]);
    foreach (prog[i]) begin
      host_action(act_instr, 2'd0, {16'd0, prog[i]}, base + addr_t'(i));
    end
  endtask

  task automatic set_wrap(input logic [1:0] m, input addr_t start, input addr_t stop);
    host_action(act_wrap, m, {22'd0, stop, start}, 5'd0);
  endtask

  task automatic set_divider(input logic [1:0] m, input div_t v);
    @(posedge clk);
    #5;
    div = v;
    host_action(act_div, m, 32'd0, 5'd0);
  endtask

  task automatic enable_machines(input logic [3:0] mask);
    host_action(act_enable, 2'd0, {28'd0, mask}, 5'd0);
  endtask

  task automatic wait_pins(input logic use_dir, input int m, input pins_t value,
                           input string what);
    pins_t cur;
    int    n;
    n   = 0;
    cur = use_dir ? window(gpio_dir, m) : window(gpio_out, m);
    while (cur !== value && n < poll_limit) begin
      @(negedge clk);
      n++;
      cur = use_dir ? window(gpio_dir, m) : window(gpio_out, m);
    end
    if (cur !== value) begin
      $display("timeout waiting for %s to reach %h", what, value);
      end_failed_run();
    end
  endtask

  task automatic pop_rx(input int m, output word_t value);
    int n;
    n = 0;
    while (rx_empty[m] && n < poll_limit) begin
      @(negedge clk);
      n++;
    end
    if (rx_empty[m]) begin
      $display("timeout waiting for receive data on machine %0d", m);
      end_failed_run();
    end
    @(posedge clk);
    #5;
    mindex = 2'(m);
    #5;
    value = dout;
    host_action(act_pull, 2'(m), 32'd0, 5'd0);
  endtask

  // clocks from one change of gpio_out bit 0 to the next
  task automatic measure_level(output int clocks);
    logic prev;
    prev   = gpio_out[0];
    clocks = 0;
    while (gpio_out[0] === prev && clocks < poll_limit) begin
      @(negedge clk);
      clocks++;
    end
    if (gpio_out[0] === prev) begin
      $display("gpio_out bit 0 stopped toggling");
      end_failed_run();
    end
  endtask

  task automatic reset_values();
    check("gpio_out", gpio_out, 32'd0);
    check("gpio_dir", gpio_dir, 32'd0);
    check("rx_empty", word_t'(rx_empty), 32'hf);
    check("tx_full", word_t'(tx_full), 32'd0);
  endtask

  task automatic set_and_enable();
    instr_t prog[$];
    prog.push_back(set_instr(dest_pindirs, 5'd31));
    prog.push_back(set_instr(dest_pins, 5'd21));
    prog.push_back(jmp_instr(cond_always, 5'd2));
    load_program(5'd0, prog);
    enable_machines(4'b0001);
    wait_pins(1'b1, 0, 8'd31, "gpio_dir[7:0]");
    wait_pins(1'b0, 0, 8'd21, "gpio_out[7:0]");
    check("gpio_dir[31:8]", word_t'(gpio_dir[31:8]), 32'd0);
    check("gpio_out[31:8]", word_t'(gpio_out[31:8]), 32'd0);
  endtask

  task automatic data_path();
    instr_t prog[$];
    word_t  w;
    pins_t  b;
    word_t  got;
    prog.push_back(set_instr(dest_pindirs, 5'd31));
    prog.push_back(set_instr(dest_pins, 5'd0));
    prog.push_back(plain_instr(op_pull));
    prog.push_back(shift_instr(op_out, 4'd8));
    prog.push_back(shift_instr(op_in, 4'd8));
    prog.push_back(plain_instr(op_push));
    prog.push_back(jmp_instr(cond_always, 5'd14));
    load_program(5'd12, prog);
    set_wrap(2'd1, 5'd12, 5'd31);
    enable_machines(4'b0011);
    wait_pins(1'b1, 1, 8'd31, "gpio_dir[15:8]");
    repeat (3) begin
      w = $urandom();
      b = 8'($urandom());
      @(posedge clk);
      #5;
      gpio_in[15:8] = b;
      host_action(act_push, 2'd1, w, 5'd0);
      wait_pins(1'b0, 1, w[7:0], "gpio_out[15:8]");
      pop_rx(1, got);
      check("dout", got, {24'd0, b});
      check("gpio_out[15:8]", word_t'(gpio_out[15:8]), {24'd0, w[7:0]});
    end
  endtask

  task automatic counted_loop();
    instr_t prog[$];
    int     n;
    word_t  got;
    n = $urandom_range(7, 0);
    prog.push_back(set_instr(dest_x, 5'(n)));
    prog.push_back(shift_instr(op_in, 4'd1));
    prog.push_back(jmp_instr(cond_x_dec, 5'd20));
    prog.push_back(plain_instr(op_push));
    prog.push_back(jmp_instr(cond_always, 5'd23));
    load_program(5'd19, prog);
    @(posedge clk);
    #5;
    gpio_in[16] = 1'b1;
    set_wrap(2'd2, 5'd19, 5'd31);
    enable_machines(4'b0111);
    pop_rx(2, got);
    // loop body runs n+1 times
    check("dout", got, word_t'((64'd1 << (n + 1)) - 64'd1));
  endtask

  task automatic wait_on_pin();
    instr_t prog[$];
    prog.push_back(set_instr(dest_pindirs, 5'd31));
    prog.push_back(wait_instr(1'b1, 3'd2));
    prog.push_back(set_instr(dest_pins, 5'd1));
    prog.push_back(jmp_instr(cond_always, 5'd27));
    load_program(5'd24, prog);
    set_wrap(2'd3, 5'd24, 5'd31);
    enable_machines(4'b1111);
    wait_pins(1'b1, 3, 8'd31, "gpio_dir[31:24]");
    repeat (20) begin
      @(negedge clk);
      check("gpio_out[31:24]", word_t'(gpio_out[31:24]), 32'd0);
    end
    @(posedge clk);
    #5;
    gpio_in[26] = 1'b1;
    wait_pins(1'b0, 3, 8'd1, "gpio_out[31:24]");
  endtask

  task automatic divider_and_wrap();
    instr_t prog[$];
    int     clocks;
    enable_machines(4'b1110);
    prog.push_back(set_instr(dest_pins, 5'd1));
    prog.push_back(set_instr(dest_pins, 5'd0));
    load_program(5'd10, prog);
    set_wrap(2'd0, 5'd10, 5'd11);
    set_divider(2'd0, 24'd3);
    enable_machines(4'b1111);
    // first change only aligns the measurement
    measure_level(clocks);
    repeat (4) begin
      measure_level(clocks);
      check("gpio_out[0] level length", word_t'(clocks), 32'd4);
    end
  endtask

  initial begin
    void'($urandom(32'h26ce));
    reset   = 1'b1;
    div     = '0;
    mindex  = 2'd0;
    din     = '0;
    index   = '0;
    action  = act_none;
    gpio_in = '0;
    repeat (8) @(posedge clk);
    #5;
    reset = 1'b0;
    reset_values();
    set_and_enable();
    data_path();
    counted_loop();
    wait_on_pin();
    divider_and_wrap();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
